// File: include/gat_params.svh
// GAT accelerator sizing macros for widths, depths and matrix shapes
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// ==================================================
// Base widths
// ==================================================
`define GAT_TOP_WIDTH           32
`define GAT_DATA_WIDTH          8
`define GAT_WH_DATA_WIDTH       20
`define GAT_NEW_FEATURE_WIDTH   32

// ==================================================
// Matrix and graph sizes
// ==================================================
`define GAT_NUM_FEATURE_IN      16
`define GAT_NUM_FEATURE_OUT     4
`define GAT_TOTAL_NODES         8
`define GAT_NUM_SUBGRAPHS       3
`define GAT_H_NUM_SPARSE_DATA   32

// Derived depths and address widths
`define GAT_H_DATA_ADDR_W       5
`define GAT_NODE_INFO_ADDR_W    3
`define GAT_WEIGHT_DEPTH        64
`define GAT_WEIGHT_ADDR_W       6
`define GAT_NEW_FEATURE_DEPTH   12
`define GAT_NEW_FEATURE_ADDR_W  4
`define GAT_COL_IDX_WIDTH       4
`define GAT_ROW_LEN_WIDTH       5

// Field widths of the stored words
`define GAT_H_DATA_WIDTH        12
`define GAT_NODE_INFO_WIDTH     6
`define GAT_LANE_IDX_W          2
`define GAT_SG_IDX_W            2

// Generic write port, sized for the widest bank
`define GAT_BRAM_ADDR_W         6
`define GAT_BRAM_DATA_W         12

`endif

// File: rtl/gat_pkg.sv
// GAT accelerator shared types for memory words, WH vectors and engine states
`include "gat_params.svh"

package gat_pkg;

  // Element types
  typedef logic signed [`GAT_DATA_WIDTH-1:0]        gat_data_t;
  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0]     wh_lane_t;
  typedef logic signed [`GAT_NEW_FEATURE_WIDTH-1:0] feat_t;
  typedef logic [`GAT_BRAM_ADDR_W-1:0]              bram_addr_t;
  typedef logic [`GAT_BRAM_DATA_W-1:0]              bram_data_t;

  // Sparse H entry, value in the upper byte and column below it
  typedef struct packed {
    gat_data_t                     value;
    logic [`GAT_COL_IDX_WIDTH-1:0] col;
  } h_data_t;

  // Per-node row info, flag marks the last node of a subgraph
  typedef struct packed {
    logic [`GAT_ROW_LEN_WIDTH-1:0] row_len;
    logic                          flag;
  } node_info_t;

  typedef struct packed {
    wh_lane_t [`GAT_NUM_FEATURE_OUT-1:0] lane;
    logic                                flag;
  } wh_t;

  // One full weight row, lane k is output column k
  typedef struct packed {
    gat_data_t [`GAT_NUM_FEATURE_OUT-1:0] w;
  } w_row_t;

  typedef struct packed {
    logic       en;
    logic       we;
    bram_addr_t addr;
    bram_data_t data;
  } bram_wr_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_INFO,
    STREAM,
    DRAIN,
    EMIT,
    DONE
  } spmm_state_e;

endpackage

// File: rtl/gat_bram_bank.sv
// Input memories for sparse H entries, node info and the weight matrix
`timescale 1ns/1ps
`include "gat_params.svh"

module gat_bram_bank
  import gat_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,

  input  bram_wr_t                         h_wr,
  input  bram_wr_t                         info_wr,
  input  bram_wr_t                         wgt_wr,

  input  logic [`GAT_H_DATA_ADDR_W-1:0]    h_raddr,
  input  logic [`GAT_NODE_INFO_ADDR_W-1:0] info_raddr,
  input  logic [`GAT_COL_IDX_WIDTH-1:0]    w_row_idx,

  output h_data_t                          h_rdata,
  output node_info_t                       info_rdata,
  output w_row_t                           w_rdata
);

  h_data_t    h_mem    [`GAT_H_NUM_SPARSE_DATA];
  node_info_t info_mem [`GAT_TOTAL_NODES];
  // Weights kept row-wise so one nonzero needs one access
  w_row_t     w_mem    [`GAT_NUM_FEATURE_IN];

  // ==================================================
  // Write ports
  // ==================================================
  always_ff @(posedge clk) begin
    if (h_wr.en && h_wr.we) begin
      h_mem[h_wr.addr[`GAT_H_DATA_ADDR_W-1:0]] <= h_data_t'(h_wr.data[`GAT_H_DATA_WIDTH-1:0]);
    end
    if (info_wr.en && info_wr.we) begin
      info_mem[info_wr.addr[`GAT_NODE_INFO_ADDR_W-1:0]] <=
        node_info_t'(info_wr.data[`GAT_NODE_INFO_WIDTH-1:0]);
    end
    // Word address is row * NUM_FEATURE_OUT + col
    if (wgt_wr.en && wgt_wr.we) begin
      w_mem[wgt_wr.addr[`GAT_WEIGHT_ADDR_W-1:`GAT_LANE_IDX_W]]
        .w[wgt_wr.addr[`GAT_LANE_IDX_W-1:0]] <= wgt_wr.data[`GAT_DATA_WIDTH-1:0];
    end
  end

  // ==================================================
  // Registered read ports
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      h_rdata    <= '0;
      info_rdata <= '0;
      w_rdata    <= '0;
    end else begin
      h_rdata    <= h_mem[h_raddr];
      info_rdata <= info_mem[info_raddr];
      w_rdata    <= w_mem[w_row_idx];
    end
  end

endmodule

// File: rtl/gat_spmm.sv
// Sparse row times dense weight engine producing one WH vector per node
`timescale 1ns/1ps
`include "gat_params.svh"

module gat_spmm
  import gat_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,

  input  logic                             h_load_done,
  input  logic                             info_load_done,
  input  logic                             wgt_load_done,

  output logic [`GAT_NODE_INFO_ADDR_W-1:0] info_raddr,
  output logic [`GAT_H_DATA_ADDR_W-1:0]    h_raddr,
  output logic [`GAT_COL_IDX_WIDTH-1:0]    w_row_idx,
  input  node_info_t                       info_rdata,
  input  h_data_t                          h_rdata,
  input  w_row_t                           w_rdata,

  output logic                             run_start,
  output logic                             wh_valid,
  output wh_t                              wh_data,
  output logic                             gat_ready,
  output logic [`GAT_TOP_WIDTH-1:0]        gat_debug_1,
  output logic [`GAT_TOP_WIDTH-1:0]        gat_debug_2
);

  spmm_state_e                       state;
  logic                              all_loaded;
  logic                              info_wait;
  logic                              emit_now;
  logic [`GAT_NODE_INFO_ADDR_W-1:0]  node_idx;
  logic [`GAT_H_DATA_ADDR_W-1:0]     h_ptr;
  logic [`GAT_ROW_LEN_WIDTH-1:0]     remain;
  logic                              node_flag;
  // s1 is the H read stage, s2 the weight read stage
  logic                              s1_vld;
  logic                              s2_vld;
  gat_data_t                         s2_val;
  wh_lane_t [`GAT_NUM_FEATURE_OUT-1:0] acc;

  assign all_loaded = h_load_done && info_load_done && wgt_load_done;
  assign emit_now   = (state == DRAIN) && !s1_vld && !s2_vld;

  assign info_raddr = node_idx;
  assign h_raddr    = h_ptr;
  // Column of the entry just read selects the weight row
  assign w_row_idx  = h_rdata.col;

  // ==================================================
  // Control FSM and accumulators
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      info_wait   <= 1'b0;
      node_idx    <= '0;
      h_ptr       <= '0;
      remain      <= '0;
      node_flag   <= 1'b0;
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      acc         <= '0;
      run_start   <= 1'b0;
      wh_valid    <= 1'b0;
      gat_ready   <= 1'b0;
      gat_debug_1 <= '0;
      gat_debug_2 <= '0;
    end else begin
      run_start <= 1'b0;
      wh_valid  <= 1'b0;
      s1_vld    <= (state == STREAM);
      s2_vld    <= s1_vld;

      if (s2_vld) begin
        for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
          acc[k] <= $signed(acc[k]) + $signed(s2_val) * $signed(w_rdata.w[k]);
        end
        gat_debug_2 <= gat_debug_2 + 1'b1;
      end

      case (state)
        IDLE: begin
          if (all_loaded && !gat_ready) begin
            state       <= FETCH_INFO;
            run_start   <= 1'b1;
            info_wait   <= 1'b0;
            node_idx    <= '0;
            h_ptr       <= '0;
            acc         <= '0;
            gat_debug_1 <= '0;
            gat_debug_2 <= '0;
          end
        end
        // First cycle presents the address, second takes the data
        FETCH_INFO: begin
          info_wait <= ~info_wait;
          if (info_wait) begin
            remain    <= info_rdata.row_len;
            node_flag <= info_rdata.flag;
            state     <= (info_rdata.row_len == '0) ? DRAIN : STREAM;
          end
        end
        STREAM: begin
          h_ptr  <= h_ptr + 1'b1;
          remain <= remain - 1'b1;
          if (remain == 1) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (emit_now) begin
            wh_valid <= 1'b1;
            state    <= EMIT;
          end
        end
        EMIT: begin
          acc         <= '0;
          gat_debug_1 <= gat_debug_1 + 1'b1;
          if (node_idx == (`GAT_TOTAL_NODES - 1)) begin
            state     <= DONE;
            gat_ready <= 1'b1;
          end else begin
            node_idx <= node_idx + 1'b1;
            state    <= FETCH_INFO;
          end
        end
        DONE: begin
          // Hold ready until software drops a load-done level
          if (!all_loaded) begin
            state     <= IDLE;
            gat_ready <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Pipeline payload
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      s2_val <= h_rdata.value;
    end
    if (emit_now) begin
      wh_data.lane <= acc;
      wh_data.flag <= node_flag;
    end
  end

endmodule

// File: rtl/gat_aggregator.sv
// Subgraph sum of WH vectors with layer activation and the feature memory
`timescale 1ns/1ps
`include "gat_params.svh"

module gat_aggregator
  import gat_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               gat_layer,
  input  logic                               run_start,
  input  logic                               wh_valid,
  input  wh_t                                wh_data,
  input  logic [`GAT_NEW_FEATURE_ADDR_W-1:0] feat_raddr,
  output logic [`GAT_NEW_FEATURE_WIDTH-1:0]  feat_rdata,
  output logic [`GAT_TOP_WIDTH-1:0]          gat_debug_3
);

  feat_t [`GAT_NUM_FEATURE_OUT-1:0]     sum;
  feat_t [`GAT_NUM_FEATURE_OUT-1:0]     sum_next;
  feat_t [`GAT_NUM_FEATURE_OUT-1:0]     out_buf;
  logic [`GAT_NEW_FEATURE_WIDTH-1:0]    feat_mem [`GAT_NEW_FEATURE_DEPTH];
  logic [`GAT_SG_IDX_W-1:0]             sg_idx;
  logic [`GAT_SG_IDX_W-1:0]             wr_sg;
  logic [`GAT_LANE_IDX_W-1:0]           wr_lane;
  logic                                 wr_en;
  logic [`GAT_NEW_FEATURE_ADDR_W-1:0]   wr_addr;

  // Sign-extend each lane into the running sum
  always_comb begin
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      sum_next[k] = sum[k] + {{(`GAT_NEW_FEATURE_WIDTH - `GAT_WH_DATA_WIDTH)
                              {wh_data.lane[k][`GAT_WH_DATA_WIDTH-1]}}, wh_data.lane[k]};
    end
  end

  // Lane count is a power of two, so s * NUM_FEATURE_OUT + k is a concat
  assign wr_addr     = {wr_sg, wr_lane};
  assign gat_debug_3 = {{(`GAT_TOP_WIDTH - `GAT_SG_IDX_W){1'b0}}, sg_idx};

  // ==================================================
  // Subgraph control
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      sum     <= '0;
      sg_idx  <= '0;
      wr_sg   <= '0;
      wr_lane <= '0;
      wr_en   <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_lane <= wr_lane + 1'b1;
        if (wr_lane == (`GAT_NUM_FEATURE_OUT - 1)) begin
          wr_en <= 1'b0;
        end
      end
      if (run_start) begin
        sum    <= '0;
        sg_idx <= '0;
      end else if (wh_valid) begin
        if (wh_data.flag) begin
          // Last node of the subgraph, start the lane writes
          sum     <= '0;
          sg_idx  <= sg_idx + 1'b1;
          wr_sg   <= sg_idx;
          wr_lane <= '0;
          wr_en   <= 1'b1;
        end else begin
          sum <= sum_next;
        end
      end
    end
  end

  // Result buffer, feature memory and read port
  always_ff @(posedge clk) begin
    if (wh_valid && wh_data.flag) begin
      for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
        // Layer 0 clamps negatives to zero
        out_buf[k] <= (!gat_layer && sum_next[k][`GAT_NEW_FEATURE_WIDTH-1]) ? '0 : sum_next[k];
      end
    end
    if (wr_en) begin
      feat_mem[wr_addr] <= out_buf[wr_lane];
    end
    feat_rdata <= feat_mem[feat_raddr];
  end

endmodule

// File: rtl/gat_top_wrapper.sv
// GAT accelerator top level with byte-addressed BRAM ports and register levels
`timescale 1ns/1ps
`include "gat_params.svh"

module gat_top_wrapper
  import gat_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,

  // ==================================================
  // Register bank
  // ==================================================
  input  logic                                 gat_layer,
  output logic                                 gat_ready,
  output logic [`GAT_TOP_WIDTH-1:0]            gat_debug_1,
  output logic [`GAT_TOP_WIDTH-1:0]            gat_debug_2,
  output logic [`GAT_TOP_WIDTH-1:0]            gat_debug_3,
  input  logic                                 h_data_bram_load_done,
  input  logic                                 h_node_info_bram_load_done,
  input  logic                                 wgt_bram_load_done,

  // ==================================================
  // BRAM ports, byte addressed
  // ==================================================
  input  logic [`GAT_TOP_WIDTH-1:0]            h_data_bram_din,
  input  logic                                 h_data_bram_ena,
  input  logic                                 h_data_bram_wea,
  input  logic [`GAT_H_DATA_ADDR_W+1:0]        h_data_bram_addra,

  input  logic [`GAT_TOP_WIDTH-1:0]            h_node_info_bram_din,
  input  logic                                 h_node_info_bram_ena,
  input  logic                                 h_node_info_bram_wea,
  input  logic [`GAT_NODE_INFO_ADDR_W+1:0]     h_node_info_bram_addra,

  input  logic [`GAT_TOP_WIDTH-1:0]            wgt_bram_din,
  input  logic                                 wgt_bram_ena,
  input  logic                                 wgt_bram_wea,
  input  logic [`GAT_WEIGHT_ADDR_W+1:0]        wgt_bram_addra,

  input  logic [`GAT_NEW_FEATURE_ADDR_W+1:0]   feat_bram_addrb,
  output logic [`GAT_NEW_FEATURE_WIDTH-1:0]    feat_bram_dout
);

  bram_wr_t                             h_wr;
  bram_wr_t                             info_wr;
  bram_wr_t                             wgt_wr;
  logic [`GAT_H_DATA_ADDR_W-1:0]        h_raddr;
  logic [`GAT_NODE_INFO_ADDR_W-1:0]     info_raddr;
  logic [`GAT_COL_IDX_WIDTH-1:0]        w_row_idx;
  h_data_t                              h_rdata;
  node_info_t                           info_rdata;
  w_row_t                               w_rdata;
  logic                                 run_start;
  logic                                 wh_valid;
  wh_t                                  wh_data;

  // Drop the byte offset and trim each data word to its field
  assign h_wr.en    = h_data_bram_ena;
  assign h_wr.we    = h_data_bram_wea;
  assign h_wr.addr  = bram_addr_t'(h_data_bram_addra[`GAT_H_DATA_ADDR_W+1:2]);
  assign h_wr.data  = bram_data_t'(h_data_bram_din[`GAT_H_DATA_WIDTH-1:0]);

  assign info_wr.en   = h_node_info_bram_ena;
  assign info_wr.we   = h_node_info_bram_wea;
  assign info_wr.addr = bram_addr_t'(h_node_info_bram_addra[`GAT_NODE_INFO_ADDR_W+1:2]);
  assign info_wr.data = bram_data_t'(h_node_info_bram_din[`GAT_NODE_INFO_WIDTH-1:0]);

  assign wgt_wr.en   = wgt_bram_ena;
  assign wgt_wr.we   = wgt_bram_wea;
  assign wgt_wr.addr = bram_addr_t'(wgt_bram_addra[`GAT_WEIGHT_ADDR_W+1:2]);
  assign wgt_wr.data = bram_data_t'(wgt_bram_din[`GAT_DATA_WIDTH-1:0]);

  gat_bram_bank u_bram_bank (
    .clk        (clk),
    .rst        (rst),
    .h_wr       (h_wr),
    .info_wr    (info_wr),
    .wgt_wr     (wgt_wr),
    .h_raddr    (h_raddr),
    .info_raddr (info_raddr),
    .w_row_idx  (w_row_idx),
    .h_rdata    (h_rdata),
    .info_rdata (info_rdata),
    .w_rdata    (w_rdata)
  );

  gat_spmm u_spmm (
    .clk            (clk),
    .rst            (rst),
    .h_load_done    (h_data_bram_load_done),
    .info_load_done (h_node_info_bram_load_done),
    .wgt_load_done  (wgt_bram_load_done),
    .info_raddr     (info_raddr),
    .h_raddr        (h_raddr),
    .w_row_idx      (w_row_idx),
    .info_rdata     (info_rdata),
    .h_rdata        (h_rdata),
    .w_rdata        (w_rdata),
    .run_start      (run_start),
    .wh_valid       (wh_valid),
    .wh_data        (wh_data),
    .gat_ready      (gat_ready),
    .gat_debug_1    (gat_debug_1),
    .gat_debug_2    (gat_debug_2)
  );

  gat_aggregator u_aggregator (
    .clk         (clk),
    .rst         (rst),
    .gat_layer   (gat_layer),
    .run_start   (run_start),
    .wh_valid    (wh_valid),
    .wh_data     (wh_data),
    .feat_raddr  (feat_bram_addrb[`GAT_NEW_FEATURE_ADDR_W+1:2]),
    .feat_rdata  (feat_bram_dout),
    .gat_debug_3 (gat_debug_3)
  );

endmodule

// File: verif/gat_chk.sv
// Bound assertions on ready after reset, WH strobe timing and feature write range
`timescale 1ns/1ps
`include "gat_params.svh"

module gat_chk (
  input logic                               clk,
  input logic                               rst,
  input logic                               gat_ready,
  input logic                               wh_valid,
  input logic                               feat_wr_en,
  input logic [`GAT_NEW_FEATURE_ADDR_W-1:0] feat_wr_addr
);

  // Count of failed assertions
  int fail_count = 0;

  // Ready comes out of reset low
  ready_after_reset: assert property (@(posedge clk) rst |=> !gat_ready)
    else begin
      $error("gat_ready high in the cycle after reset");
      fail_count++;
    end

  // WH strobes belong to a run in progress
  strobe_while_busy: assert property (@(posedge clk) disable iff (rst)
    wh_valid |-> !gat_ready)
    else begin
      $error("wh_valid seen while gat_ready is high");
      fail_count++;
    end

  feat_addr_range: assert property (@(posedge clk) disable iff (rst)
    feat_wr_en |-> (feat_wr_addr < (`GAT_NUM_FEATURE_OUT * `GAT_NUM_SUBGRAPHS)))
    else begin
      $error("feature write address %0d out of range", feat_wr_addr);
      fail_count++;
    end

endmodule

bind gat_top_wrapper gat_chk u_chk (
  .clk          (clk),
  .rst          (rst),
  .gat_ready    (gat_ready),
  .wh_valid     (wh_valid),
  .feat_wr_en   (u_aggregator.wr_en),
  .feat_wr_addr (u_aggregator.wr_addr)
);

// File: verif/gat_tb.sv
// GAT accelerator testbench driving loads, runs and feature readback from a vector file
`timescale 1ns/1ps
`include "gat_params.svh"

module gat_tb;

  localparam int VEC_DEPTH = 256;
  localparam int RUN_LIMIT = 400;

  logic                                 clk;
  logic                                 rst;
  logic                                 gat_layer;
  logic                                 gat_ready;
  logic [`GAT_TOP_WIDTH-1:0]            gat_debug_1;
  logic [`GAT_TOP_WIDTH-1:0]            gat_debug_2;
  logic [`GAT_TOP_WIDTH-1:0]            gat_debug_3;
  logic                                 h_data_bram_load_done;
  logic                                 h_node_info_bram_load_done;
  logic                                 wgt_bram_load_done;
  logic [`GAT_TOP_WIDTH-1:0]            h_data_bram_din;
  logic                                 h_data_bram_ena;
  logic                                 h_data_bram_wea;
  logic [`GAT_H_DATA_ADDR_W+1:0]        h_data_bram_addra;
  logic [`GAT_TOP_WIDTH-1:0]            h_node_info_bram_din;
  logic                                 h_node_info_bram_ena;
  logic                                 h_node_info_bram_wea;
  logic [`GAT_NODE_INFO_ADDR_W+1:0]     h_node_info_bram_addra;
  logic [`GAT_TOP_WIDTH-1:0]            wgt_bram_din;
  logic                                 wgt_bram_ena;
  logic                                 wgt_bram_wea;
  logic [`GAT_WEIGHT_ADDR_W+1:0]        wgt_bram_addra;
  logic [`GAT_NEW_FEATURE_ADDR_W+1:0]   feat_bram_addrb;
  logic [`GAT_NEW_FEATURE_WIDTH-1:0]    feat_bram_dout;

  logic [31:0] vec [VEC_DEPTH];
  integer      seed = 32'h94be_ba71;
  int          watchdog_cycles = 0;
  int          run_idx = 0;

  gat_top_wrapper DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==================================================
  // Helper tasks
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic wait_ready(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (gat_ready !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (gat_ready !== level) begin
      $display("gat_ready did not go to %0d within %0d cycles during %s", level, limit, what);
      $display("test failed");
      $fatal(1, "ready timeout");
    end
  endtask

  // Random byte offset and junk upper din bits, both must be ignored
  task automatic write_word(input logic [3:0] op, input logic [7:0] addr,
                            input logic [15:0] data);
    logic [1:0]  off;
    logic [31:0] din;
    int          idle;
    off  = 2'($unsigned($random(seed)));
    din  = {16'($unsigned($random(seed))), data};
    idle = $unsigned($random(seed)) % 4;
    @(negedge clk);
    case (op)
      4'h1: begin
        h_data_bram_ena   = 1'b1;
        h_data_bram_wea   = 1'b1;
        h_data_bram_addra = {addr[`GAT_H_DATA_ADDR_W-1:0], off};
        h_data_bram_din   = din;
      end
      4'h2: begin
        h_node_info_bram_ena   = 1'b1;
        h_node_info_bram_wea   = 1'b1;
        h_node_info_bram_addra = {addr[`GAT_NODE_INFO_ADDR_W-1:0], off};
        h_node_info_bram_din   = din;
      end
      default: begin
        wgt_bram_ena   = 1'b1;
        wgt_bram_wea   = 1'b1;
        wgt_bram_addra = {addr[`GAT_WEIGHT_ADDR_W-1:0], off};
        wgt_bram_din   = din;
      end
    endcase
    @(negedge clk);
    h_data_bram_ena      = 1'b0;
    h_data_bram_wea      = 1'b0;
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    wgt_bram_ena         = 1'b0;
    wgt_bram_wea         = 1'b0;
    repeat (idle) @(negedge clk);
  endtask

  task automatic read_feature(input int word, input logic [1:0] off,
                              output logic [31:0] data);
    @(negedge clk);
    feat_bram_addrb = {word[`GAT_NEW_FEATURE_ADDR_W-1:0], off};
    @(negedge clk);
    data = feat_bram_dout;
  endtask

  // Run word is {op, nnz, nodes, subgraphs, layer}
  task automatic start_run(input logic [31:0] cmd);
    string tag;
    run_idx++;
    tag = $sformatf("run%0d", run_idx);
    if (gat_ready === 1'b1) begin
      @(negedge clk);
      wgt_bram_load_done = 1'b0;
      wait_ready(1'b0, 20, {tag, " load-done drop"});
    end
    @(negedge clk);
    gat_layer                  = cmd[0];
    h_data_bram_load_done      = 1'b1;
    h_node_info_bram_load_done = 1'b1;
    // Hold two levels for longer than a whole run takes
    repeat (cmd[27:20] + 8 * cmd[19:12]) @(negedge clk);
    check_value({tag, " ready before weight load"}, 32'd0, {31'd0, gat_ready});
    wgt_bram_load_done = 1'b1;
    wait_ready(1'b1, RUN_LIMIT, tag);
    check_value({tag, " node count"}, {24'd0, cmd[19:12]}, gat_debug_1);
    check_value({tag, " nonzero count"}, {24'd0, cmd[27:20]}, gat_debug_2);
    check_value({tag, " subgraph count"}, {24'd0, cmd[11:4]}, gat_debug_3);
  endtask

  // ==================================================
  // Watchdog
  // ==================================================
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

  // ==================================================
  // Bound assertion monitor
  // ==================================================
  initial begin
    wait (DUT.u_chk.fail_count != 0);
    $display("A bound assertion on the DUT failed, see the error above");
    $display("test failed");
    $fatal(1, "assertion failure");
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int          pc;
    int          n;
    logic [1:0]  off;
    logic [31:0] got;
    rst                        = 1'b1;
    gat_layer                  = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    feat_bram_addrb            = '0;

    $readmemh("verif/gat_vectors.hex", vec);
    pc = 0;
    while (pc < VEC_DEPTH && vec[pc][31:28] !== 4'hF) begin
      pc++;
    end
    if (pc == VEC_DEPTH) begin
      $display("Vector file has no end marker");
      $display("test failed");
      $fatal(1, "bad vector file");
    end
    watchdog_cycles = 200 * (pc + 1) + 2000;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("ready after reset", 32'd0, {31'd0, gat_ready});

    pc = 0;
    while (vec[pc][31:28] !== 4'hF) begin
      case (vec[pc][31:28])
        4'h1, 4'h2, 4'h3: begin
          write_word(vec[pc][31:28], vec[pc][23:16], vec[pc][15:0]);
          pc++;
        end
        4'h4: begin
          start_run(vec[pc]);
          pc++;
        end
        4'h5: begin
          n = vec[pc][7:0];
          for (int i = 0; i < n; i++) begin
            off = 2'($unsigned($random(seed)) % 3 + 1);
            read_feature(i, 2'b00, got);
            check_value($sformatf("run%0d feature %0d", run_idx, i), vec[pc + 1 + i], got);
            read_feature(i, off, got);
            check_value($sformatf("run%0d feature %0d offset %0d", run_idx, i, off),
                        vec[pc + 1 + i], got);
          end
          pc = pc + n + 1;
        end
        default: begin
          $display("Unknown opcode in vector word %0d: %h", pc, vec[pc]);
          $display("test failed");
          $fatal(1, "bad vector opcode");
        end
      endcase
    end

    $display("test passed");
    $finish;
  end

endmodule

// File: verif/gat_vectors.hex
// Columns: [31:28] op, [23:16] word address, [15:0] data; op 1 H, 2 node info, 3 weight
// op 4 run {nnz[27:20], nodes[19:12], subgraphs[11:4], layer[0]}, op 5 count then words, F end
// Weight rows 2, 5, 9 and 14, lanes 0 to 3
30080003 300900FE 300A0001 300B0000
301400FC 30150002 30160000 30170005
30240001 30250001 302600FD 30270002
30380002 303900FF 303A0004 303B00FA
// H entries {value, col} in node order, nodes 2 and 5 are empty
10000022 10010FFE
10020015 10030039 10040FE2
10050049
10060FD5 1007001E
10080022 1009002E 100A0FF9
100B0055
// Node info {row_len, last flag}, subgraphs of 1, 2 and 5 nodes
20000005 20010006 20020001 20030002
20040004 20050000 20060006 20070003
// Layer 1 run, signed sums
40C08031
5000000C
00000004 FFFFFFFD FFFFFFFE 00000006
FFFFFFF9 00000009 FFFFFFF5 0000000B
00000007 00000000 00000005 FFFFFFFE
// Layer 0 run, negative lanes clamped
40C08030
5000000C
00000004 00000000 00000000 00000006
00000000 00000009 00000000 0000000B
00000007 00000000 00000005 00000000
// End marker
F0000000

// File: verilog.f
+incdir+include
rtl/gat_pkg.sv
rtl/gat_bram_bank.sv
rtl/gat_spmm.sv
rtl/gat_aggregator.sv
rtl/gat_top_wrapper.sv
verif/gat_chk.sv
verif/gat_tb.sv

// File: Bender.yml
package:
  name: gat_accel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/gat_pkg.sv
      - rtl/gat_bram_bank.sv
      - rtl/gat_spmm.sv
      - rtl/gat_aggregator.sv
      - rtl/gat_top_wrapper.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/gat_chk.sv
      - verif/gat_tb.sv
